// File: Makefile
TOP = tb_cpu_core
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+.
cpu_pkg.sv
regfile.sv
rob.sv
instr_fetch.sv
instr_issue.sv
instr_exec.sv
instr_commit.sv
cpu_core.sv
tb_cpu_core.sv

// File: cpu_core.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu_core (
	input  logic               clk,
	input  logic               rst_n,
	output logic               fetch_read,
	output cpu_pkg::uint32_t   fetch_addr,
	input  logic               fetch_valid,
	input  cpu_pkg::uint32_t   fetch_data,
	output logic               commit_valid,
	output cpu_pkg::reg_addr_t commit_rd,
	output cpu_pkg::uint32_t   commit_data
);

// register file
logic                     reg_we;
cpu_pkg::reg_addr_t       reg_waddr;
cpu_pkg::uint32_t         reg_wdata;
cpu_pkg::reg_addr_t [1:0] reg_raddr;
cpu_pkg::uint32_t   [1:0] reg_rdata;

// register status, port 1 is issue
logic                             issue_status_we, commit_status_we;
cpu_pkg::reg_addr_t               issue_status_waddr, commit_status_waddr;
cpu_pkg::register_status_t        issue_status_wdata, commit_status_wdata;
cpu_pkg::register_status_t [2:0]  status_rdata;

cpu_pkg::cdb_packet_t cdb;

// rob
logic                          rob_push, rob_pop, rob_full, rob_empty;
cpu_pkg::rob_packet_t          rob_push_data, rob_pop_data;
cpu_pkg::rob_index_t           rob_head, rob_reorder;
cpu_pkg::rob_index_t  [1:0]    rob_raddr;
cpu_pkg::rob_packet_t [1:0]    rob_rdata;

// fetch and stations
cpu_pkg::fetch_entry_t     if_fetch_entry;
logic                      if_fetch_ack;
logic [`RS_NUM-1:0]        rs_free, rs_we;
cpu_pkg::reserve_station_t issue_rs;

regfile #(
	.WRITE_PORTS ( 1                  ),
	.READ_PORTS  ( 2                  ),
	.dtype       ( cpu_pkg::uint32_t  )
) regfile_inst (
	.clk,
	.rst_n,
	.we    ( reg_we    ),
	.waddr ( reg_waddr ),
	.wdata ( reg_wdata ),
	.raddr ( reg_raddr ),
	.rdata ( reg_rdata )
);

regfile #(
	.WRITE_PORTS ( 2                          ),
	.READ_PORTS  ( 3                          ),
	.dtype       ( cpu_pkg::register_status_t )
) regfile_status_inst (
	.clk,
	.rst_n,
	.we    ( {issue_status_we, commit_status_we}       ),
	.waddr ( {issue_status_waddr, commit_status_waddr} ),
	.wdata ( {issue_status_wdata, commit_status_wdata} ),
	.raddr ( {rob_pop_data.rd, reg_raddr}              ),
	.rdata ( status_rdata                              )
);

rob rob_inst (
	.clk,
	.rst_n,
	.push    ( rob_push      ),
	.data_i  ( rob_push_data ),
	.pop     ( rob_pop       ),
	.data_o  ( rob_pop_data  ),
	.head    ( rob_head      ),
	.full    ( rob_full      ),
	.empty   ( rob_empty     ),
	.reorder ( rob_reorder   ),
	.rob_raddr,
	.rob_rdata,
	.cdb
);

instr_fetch instr_fetch_inst (
	.clk,
	.rst_n,
	.fetch_read,
	.fetch_addr,
	.fetch_valid,
	.fetch_data,
	.fetch_ack   ( if_fetch_ack   ),
	.fetch_entry ( if_fetch_entry )
);

instr_issue instr_issue_inst (
	.fetch_entry  ( if_fetch_entry      ),
	.fetch_ack    ( if_fetch_ack        ),
	.rob_full,
	.rob_reorder,
	.rob_push,
	.rob_packet   ( rob_push_data       ),
	.rob_raddr,
	.rob_rdata,
	.cdb,
	.rs_free,
	.rs_we,
	.rs           ( issue_rs            ),
	.reg_raddr,
	.reg_rdata,
	.reg_status   ( status_rdata[1:0]   ),
	.status_we    ( issue_status_we     ),
	.status_waddr ( issue_status_waddr  ),
	.status_wdata ( issue_status_wdata  )
);

instr_exec instr_exec_inst (
	.clk,
	.rst_n,
	.rs_we,
	.rs_i    ( issue_rs ),
	.rs_free,
	.cdb_o   ( cdb      )
);

instr_commit instr_commit_inst (
	.rob_packet    ( rob_pop_data        ),
	.rob_empty,
	.rob_head,
	.rob_ack       ( rob_pop             ),
	.reg_we,
	.reg_waddr,
	.reg_wdata,
	.commit_status ( status_rdata[2]     ),
	.status_we     ( commit_status_we    ),
	.status_waddr  ( commit_status_waddr ),
	.status_wdata  ( commit_status_wdata ),
	.commit_valid,
	.commit_rd,
	.commit_data
);

endmodule

// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// architectural registers, r0 hardwired to zero
`define REG_NUM 16

// reorder buffer entries, power of two
`define ROB_DEPTH 8

// alu reservation stations
`define RS_NUM 2

`endif

// File: cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [$clog2(`REG_NUM)-1:0] reg_addr_t;
typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_index_t;

typedef enum logic [3:0] {
	op_add  = 4'd0,
	op_sub  = 4'd1,
	op_and  = 4'd2,
	op_or   = 4'd3,
	op_xor  = 4'd4,
	op_addi = 4'd5
} opcode_t;

// instruction word layout, msb first
typedef struct packed {
	opcode_t     op;
	reg_addr_t   rd;
	reg_addr_t   rs1;
	reg_addr_t   rs2;
	logic [15:0] imm;
} instr_t;

typedef struct packed {
	logic       busy;
	rob_index_t idx;
} register_status_t;

typedef struct packed {
	logic       valid;
	rob_index_t tag;
	uint32_t    value;
} operand_t;

typedef struct packed {
	logic            busy;
	opcode_t         op;
	operand_t  [1:0] operand;
	rob_index_t      dest;
} reserve_station_t;

typedef struct packed {
	logic      done;
	reg_addr_t rd;
	uint32_t   result;
} rob_packet_t;

typedef struct packed {
	logic       valid;
	rob_index_t tag;
	uint32_t    value;
} cdb_packet_t;

typedef struct packed {
	logic    valid;
	uint32_t instr;
} fetch_entry_t;

endpackage

// File: instr_commit.sv
`timescale 1ns/100ps

module instr_commit (
	input  cpu_pkg::rob_packet_t      rob_packet,
	input  logic                      rob_empty,
	input  cpu_pkg::rob_index_t       rob_head,
	output logic                      rob_ack,
	output logic                      reg_we,
	output cpu_pkg::reg_addr_t        reg_waddr,
	output cpu_pkg::uint32_t          reg_wdata,
	input  cpu_pkg::register_status_t commit_status,
	output logic                      status_we,
	output cpu_pkg::reg_addr_t        status_waddr,
	output cpu_pkg::register_status_t status_wdata,
	output logic                      commit_valid,
	output cpu_pkg::reg_addr_t        commit_rd,
	output cpu_pkg::uint32_t          commit_data
);

assign rob_ack = !rob_empty && rob_packet.done;

assign reg_we    = rob_ack && (rob_packet.rd != '0);
assign reg_waddr = rob_packet.rd;
assign reg_wdata = rob_packet.result;

// only clear if no younger instruction renamed rd
assign status_we    = reg_we && commit_status.busy && (commit_status.idx == rob_head);
assign status_waddr = rob_packet.rd;
assign status_wdata = '0;

assign commit_valid = rob_ack;
assign commit_rd    = rob_packet.rd;
assign commit_data  = rob_packet.result;

endmodule

// File: instr_exec.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module instr_exec (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                      [`RS_NUM-1:0] rs_we,
	input  cpu_pkg::reserve_station_t              rs_i,
	output logic                      [`RS_NUM-1:0] rs_free,
	output cpu_pkg::cdb_packet_t                   cdb_o
);

localparam int SEL_W = (`RS_NUM > 1) ? $clog2(`RS_NUM) : 1;

cpu_pkg::reserve_station_t [`RS_NUM-1:0] st;
logic [`RS_NUM-1:0] busy;
logic [`RS_NUM-1:0] ready;
logic [`RS_NUM-1:0] grant;
logic [SEL_W-1:0] sel;
cpu_pkg::uint32_t alu_result;

function automatic cpu_pkg::uint32_t alu(input cpu_pkg::opcode_t op,
	input cpu_pkg::uint32_t a, input cpu_pkg::uint32_t b);
	case (op)
		cpu_pkg::op_sub: return a - b;
		cpu_pkg::op_and: return a & b;
		cpu_pkg::op_or:  return a | b;
		cpu_pkg::op_xor: return a ^ b;
		default:         return a + b;
	endcase
endfunction

always_comb begin
	for (int i = 0; i < `RS_NUM; i++) begin
		busy[i]  = st[i].busy;
		ready[i] = st[i].busy && st[i].operand[0].valid && st[i].operand[1].valid;
	end
end

assign rs_free = ~busy;

// lowest ready station goes first
always_comb begin
	grant = '0;
	sel   = '0;
	for (int i = `RS_NUM - 1; i >= 0; i--) begin
		if (ready[i]) begin
			grant    = '0;
			grant[i] = 1'b1;
			sel      = SEL_W'(i);
		end
	end
end

assign alu_result = alu(st[sel].op, st[sel].operand[0].value, st[sel].operand[1].value);

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		st    <= '0;
		cdb_o <= '0;
	end else begin
		cdb_o.valid <= |ready;
		cdb_o.tag   <= st[sel].dest;
		cdb_o.value <= alu_result;
		for (int i = 0; i < `RS_NUM; i++) begin
			if (rs_we[i]) begin
				st[i] <= rs_i;
			end else begin
				if (grant[i])
					st[i].busy <= 1'b0;
				// wakeup on the broadcast result
				for (int j = 0; j < 2; j++) begin
					if (st[i].busy && !st[i].operand[j].valid && cdb_o.valid
						&& cdb_o.tag == st[i].operand[j].tag) begin
						st[i].operand[j].valid <= 1'b1;
						st[i].operand[j].value <= cdb_o.value;
					end
				end
			end
		end
	end
end

assert property (@(posedge clk) disable iff (!rst_n) (rs_we & busy) == '0);

endmodule

// File: instr_fetch.sv
`timescale 1ns/100ps

module instr_fetch (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic                  fetch_read,
	output cpu_pkg::uint32_t      fetch_addr,
	input  logic                  fetch_valid,
	input  cpu_pkg::uint32_t      fetch_data,
	input  logic                  fetch_ack,
	output cpu_pkg::fetch_entry_t fetch_entry
);

cpu_pkg::uint32_t pc;
logic pending;
logic buf_valid;
cpu_pkg::uint32_t buf_instr;
logic request;

// buffer empty or leaving this cycle, nothing in flight
assign request = !pending && (!buf_valid || fetch_ack);

assign fetch_entry.valid = buf_valid;
assign fetch_entry.instr = buf_instr;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc         <= '0;
		pending    <= 1'b0;
		fetch_read <= 1'b0;
		fetch_addr <= '0;
		buf_valid  <= 1'b0;
	end else begin
		fetch_read <= request;
		if (request) begin
			fetch_addr <= pc;
			pc         <= pc + 32'd4;
			pending    <= 1'b1;
		end else if (fetch_valid) begin
			pending <= 1'b0;
		end
		if (fetch_valid)
			buf_valid <= 1'b1;
		else if (fetch_ack)
			buf_valid <= 1'b0;
	end
end

always_ff @(posedge clk) begin
	if (fetch_valid)
		buf_instr <= fetch_data;
end

assert property (@(posedge clk) disable iff (!rst_n) fetch_valid |-> pending);

endmodule

// File: instr_issue.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module instr_issue (
	input  cpu_pkg::fetch_entry_t                  fetch_entry,
	output logic                                   fetch_ack,
	input  logic                                   rob_full,
	input  cpu_pkg::rob_index_t                    rob_reorder,
	output logic                                   rob_push,
	output cpu_pkg::rob_packet_t                   rob_packet,
	output cpu_pkg::rob_index_t       [1:0]        rob_raddr,
	input  cpu_pkg::rob_packet_t      [1:0]        rob_rdata,
	input  cpu_pkg::cdb_packet_t                   cdb,
	input  logic                      [`RS_NUM-1:0] rs_free,
	output logic                      [`RS_NUM-1:0] rs_we,
	output cpu_pkg::reserve_station_t              rs,
	output cpu_pkg::reg_addr_t        [1:0]        reg_raddr,
	input  cpu_pkg::uint32_t          [1:0]        reg_rdata,
	input  cpu_pkg::register_status_t [1:0]        reg_status,
	output logic                                   status_we,
	output cpu_pkg::reg_addr_t                     status_waddr,
	output cpu_pkg::register_status_t              status_wdata
);

cpu_pkg::instr_t instr;
cpu_pkg::operand_t [1:0] operand;
logic issue;

assign instr = fetch_entry.instr;
assign issue = fetch_entry.valid && !rob_full && (|rs_free);

assign fetch_ack = issue;
assign reg_raddr = {instr.rs2, instr.rs1};
assign rob_raddr = {reg_status[1].idx, reg_status[0].idx};

assign rob_push          = issue;
assign rob_packet.done   = 1'b0;
assign rob_packet.rd     = instr.rd;
assign rob_packet.result = '0;

// rename rd onto the new rob slot
assign status_we          = issue && (instr.rd != '0);
assign status_waddr       = instr.rd;
assign status_wdata.busy  = 1'b1;
assign status_wdata.idx   = rob_reorder;

always_comb begin
	for (int i = 0; i < 2; i++) begin
		operand[i].tag   = reg_status[i].idx;
		operand[i].valid = 1'b1;
		if (!reg_status[i].busy)
			operand[i].value = reg_rdata[i];
		else if (rob_rdata[i].done)
			operand[i].value = rob_rdata[i].result;
		else if (cdb.valid && cdb.tag == reg_status[i].idx)
			operand[i].value = cdb.value;
		else begin
			operand[i].valid = 1'b0;
			operand[i].value = '0;
		end
	end
	// addi takes the immediate in place of rs2
	if (instr.op == cpu_pkg::op_addi) begin
		operand[1].valid = 1'b1;
		operand[1].tag   = '0;
		operand[1].value = {{16{instr.imm[15]}}, instr.imm};
	end
end

// lowest free station wins
always_comb begin
	rs_we = '0;
	for (int i = `RS_NUM - 1; i >= 0; i--) begin
		if (rs_free[i]) begin
			rs_we    = '0;
			rs_we[i] = issue;
		end
	end
end

assign rs.busy    = 1'b1;
assign rs.op      = instr.op;
assign rs.operand = operand;
assign rs.dest    = rob_reorder;

endmodule

// File: regfile.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module regfile #(
	parameter int  WRITE_PORTS = 1,
	parameter int  READ_PORTS  = 2,
	parameter type dtype       = cpu_pkg::uint32_t
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic               [WRITE_PORTS-1:0] we,
	input  cpu_pkg::reg_addr_t [WRITE_PORTS-1:0] waddr,
	input  dtype               [WRITE_PORTS-1:0] wdata,
	input  cpu_pkg::reg_addr_t [READ_PORTS-1:0]  raddr,
	output dtype               [READ_PORTS-1:0]  rdata
);

dtype regs [`REG_NUM];

// later ports overwrite earlier ones on the same address
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < `REG_NUM; i++)
			regs[i] <= '0;
	end else begin
		for (int i = 0; i < WRITE_PORTS; i++) begin
			if (we[i] && waddr[i] != '0)
				regs[waddr[i]] <= wdata[i];
		end
	end
end

always_comb begin
	for (int i = 0; i < READ_PORTS; i++)
		rdata[i] = (raddr[i] == '0) ? dtype'('0) : regs[raddr[i]];
end

endmodule

// File: rob.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module rob (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             push,
	input  cpu_pkg::rob_packet_t             data_i,
	input  logic                             pop,
	output cpu_pkg::rob_packet_t             data_o,
	output cpu_pkg::rob_index_t              head,
	output logic                             full,
	output logic                             empty,
	output cpu_pkg::rob_index_t              reorder,
	input  cpu_pkg::rob_index_t  [1:0]       rob_raddr,
	output cpu_pkg::rob_packet_t [1:0]       rob_rdata,
	input  cpu_pkg::cdb_packet_t             cdb
);

cpu_pkg::rob_packet_t entries [`ROB_DEPTH];
cpu_pkg::rob_index_t tail;
logic [$clog2(`ROB_DEPTH):0] count;
// distance of the cdb tag from the head
cpu_pkg::rob_index_t cdb_offset;

assign full       = (count == `ROB_DEPTH);
assign empty      = (count == '0);
assign reorder    = tail;
assign data_o     = entries[head];
assign cdb_offset = cdb.tag - head;

assign rob_rdata[0] = entries[rob_raddr[0]];
assign rob_rdata[1] = entries[rob_raddr[1]];

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		head  <= '0;
		tail  <= '0;
		count <= '0;
	end else begin
		if (push)
			tail <= tail + 1'b1;
		if (pop)
			head <= head + 1'b1;
		case ({push, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (push)
		entries[tail] <= data_i;
	// result capture from the cdb
	if (cdb.valid) begin
		entries[cdb.tag].done   <= 1'b1;
		entries[cdb.tag].result <= cdb.value;
	end
end

assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);
assert property (@(posedge clk) disable iff (!rst_n) cdb.valid |-> (cdb_offset < count));

endmodule

// File: tb_cpu_core.sv
`timescale 1ns/100ps

module tb_cpu_core;

localparam int TEST_NUM    = 5;
localparam int INSTR_TOTAL = 69;
// reset and settling per test and 12 cycles per instruction
localparam int CYCLE_LIMIT = TEST_NUM * 20 + 12 * INSTR_TOTAL;

logic               clk;
logic               rst_n;
logic               fetch_read;
cpu_pkg::uint32_t   fetch_addr;
logic               fetch_valid = 1'b0;
cpu_pkg::uint32_t   fetch_data = '0;
logic               commit_valid;
cpu_pkg::reg_addr_t commit_rd;
cpu_pkg::uint32_t   commit_data;

// program image and reference state
logic [31:0]      prog [64];
int               prog_len = 0;
int               expect_nz = 0;
cpu_pkg::uint32_t model_regs [16];
int               commit_idx = 0;
int               nz_commits = 0;

integer           seed = 90196;
logic             rand_delay = 1'b0;
cpu_pkg::uint32_t req_addr = '0;
logic [2:0]       req_wait = '0;

string cur_test = "init";
int    errors = 0;
int    test_errors_start = 0;
int    tests_run = 0;
int    tests_failed = 0;
int    cycles = 0;

cpu_core UUT (
	.clk,
	.rst_n,
	.fetch_read,
	.fetch_addr,
	.fetch_valid,
	.fetch_data,
	.commit_valid,
	.commit_rd,
	.commit_data
);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

function automatic logic [31:0] mem_word(input cpu_pkg::uint32_t addr);
	int idx;
	idx = int'(addr >> 2);
	// past the program the core sees add r0, r0, r0
	if (idx < prog_len)
		return prog[idx];
	return 32'h0;
endfunction

function automatic cpu_pkg::uint32_t model_result(input logic [31:0] w);
	cpu_pkg::uint32_t a;
	cpu_pkg::uint32_t b;
	a = model_regs[w[23:20]];
	b = model_regs[w[19:16]];
	case (w[31:28])
		cpu_pkg::op_add:  return a + b;
		cpu_pkg::op_sub:  return a - b;
		cpu_pkg::op_and:  return a & b;
		cpu_pkg::op_or:   return a | b;
		cpu_pkg::op_xor:  return a ^ b;
		cpu_pkg::op_addi: return a + {{16{w[15]}}, w[15:0]};
		default:          return 32'h0;
	endcase
endfunction

task automatic check_rd(input string what, input cpu_pkg::reg_addr_t exp,
	input cpu_pkg::reg_addr_t act);
	if (act !== exp) begin
		errors++;
		$display("[FAIL] %s: %s expected %0d, got %0d", cur_test, what, exp, act);
	end
endtask

task automatic check_data(input string what, input cpu_pkg::uint32_t exp,
	input cpu_pkg::uint32_t act);
	if (act !== exp) begin
		errors++;
		$display("[FAIL] %s: %s expected %08h, got %08h", cur_test, what, exp, act);
	end
endtask

task automatic note_error(input string msg);
	errors++;
	$display("error in %s: %s", cur_test, msg);
endtask

// memory answers each request after 1 to 4 cycles
always @(posedge clk) begin : fetch_memory
	logic [2:0] delay;
	fetch_valid <= 1'b0;
	if (!rst_n) begin
		req_wait <= '0;
	end else if (fetch_read) begin
		delay = rand_delay ? 3'(({$random(seed)} % 4) + 1) : 3'd1;
		if (delay == 3'd1) begin
			fetch_valid <= 1'b1;
			fetch_data  <= mem_word(fetch_addr);
		end else begin
			req_addr <= fetch_addr;
			req_wait <= delay - 3'd1;
		end
	end else if (req_wait == 3'd1) begin
		fetch_valid <= 1'b1;
		fetch_data  <= mem_word(req_addr);
		req_wait    <= '0;
	end else if (req_wait > 3'd1) begin
		req_wait <= req_wait - 3'd1;
	end
end

// commit monitor walking the program in order next to the core
always @(negedge clk) begin : commit_monitor
	logic [31:0]      word;
	cpu_pkg::uint32_t exp_data;
	if (!rst_n) begin
		commit_idx = 0;
		nz_commits = 0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
	end else if (commit_valid) begin
		word     = mem_word(cpu_pkg::uint32_t'(commit_idx * 4));
		exp_data = model_result(word);
		check_rd("commit_rd", word[27:24], commit_rd);
		check_data("commit_data", exp_data, commit_data);
		if (word[27:24] != 4'd0) begin
			model_regs[word[27:24]] = exp_data;
			nz_commits++;
		end
		commit_idx++;
	end
end

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles >= CYCLE_LIMIT) begin
		$display("timeout after %0d cycles in %s, the core hung", cycles, cur_test);
		$display("Verification failed");
		$finish;
	end
end

task automatic hold_reset();
	@(posedge clk);
	rst_n <= 1'b0;
	repeat (16) begin
		@(negedge clk);
		if (fetch_read || commit_valid)
			note_error("fetch_read or commit_valid went high during reset");
	end
endtask

task automatic release_reset();
	@(posedge clk);
	rst_n <= 1'b1;
	@(negedge clk);
	if (fetch_read || commit_valid)
		note_error("fetch_read or commit_valid high right after reset");
endtask

task automatic start_test(input string name);
	cur_test          = name;
	test_errors_start = errors;
	hold_reset();
	prog_len          = 0;
	expect_nz         = 0;
	rand_delay        = 1'b0;
endtask

task automatic add_instr(input cpu_pkg::opcode_t op, input logic [3:0] rd,
	input logic [3:0] rs1, input logic [3:0] rs2, input logic [15:0] imm);
	prog[prog_len] = {op, rd, rs1, rs2, imm};
	prog_len++;
	if (rd != 4'd0)
		expect_nz++;
endtask

task automatic end_test();
	while (nz_commits < expect_nz)
		@(negedge clk);
	tests_run++;
	if (errors != test_errors_start)
		tests_failed++;
	$display("test %s done, %0d errors", cur_test, errors - test_errors_start);
endtask

task automatic reset_fetch_test();
	start_test("reset_fetch");
	release_reset();
	for (int k = 0; k < 4; k++) begin
		@(negedge clk);
		while (!fetch_read)
			@(negedge clk);
		check_data("fetch_addr", cpu_pkg::uint32_t'(k * 4), fetch_addr);
	end
	end_test();
endtask

task automatic independent_ops_test();
	start_test("independent_ops");
	add_instr(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd0, 16'h1234);
	add_instr(cpu_pkg::op_addi, 4'd2, 4'd0, 4'd0, 16'hfed4);
	add_instr(cpu_pkg::op_addi, 4'd3, 4'd0, 4'd0, 16'h0f0f);
	add_instr(cpu_pkg::op_add, 4'd4, 4'd1, 4'd2, 16'h0);
	add_instr(cpu_pkg::op_sub, 4'd5, 4'd1, 4'd3, 16'h0);
	add_instr(cpu_pkg::op_and, 4'd6, 4'd2, 4'd3, 16'h0);
	add_instr(cpu_pkg::op_or, 4'd7, 4'd1, 4'd3, 16'h0);
	add_instr(cpu_pkg::op_xor, 4'd8, 4'd2, 4'd1, 16'h0);
	add_instr(cpu_pkg::op_addi, 4'd9, 4'd0, 4'd0, 16'hffff);
	release_reset();
	end_test();
endtask

task automatic dependency_chain_test();
	start_test("dependency_chain");
	add_instr(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd0, 16'd5);
	add_instr(cpu_pkg::op_add, 4'd2, 4'd1, 4'd1, 16'h0);
	add_instr(cpu_pkg::op_add, 4'd3, 4'd2, 4'd1, 16'h0);
	add_instr(cpu_pkg::op_sub, 4'd4, 4'd3, 4'd2, 16'h0);
	add_instr(cpu_pkg::op_xor, 4'd5, 4'd4, 4'd4, 16'h0);
	add_instr(cpu_pkg::op_or, 4'd6, 4'd5, 4'd3, 16'h0);
	add_instr(cpu_pkg::op_addi, 4'd6, 4'd6, 4'd0, 16'hfffe);
	add_instr(cpu_pkg::op_and, 4'd7, 4'd6, 4'd6, 16'h0);
	add_instr(cpu_pkg::op_add, 4'd1, 4'd1, 4'd7, 16'h0);
	add_instr(cpu_pkg::op_add, 4'd2, 4'd1, 4'd2, 16'h0);
	release_reset();
	end_test();
endtask

task automatic zero_register_test();
	start_test("zero_register");
	add_instr(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd0, 16'd9);
	add_instr(cpu_pkg::op_addi, 4'd0, 4'd1, 4'd0, 16'd3);
	add_instr(cpu_pkg::op_add, 4'd0, 4'd1, 4'd1, 16'h0);
	add_instr(cpu_pkg::op_add, 4'd2, 4'd0, 4'd1, 16'h0);
	add_instr(cpu_pkg::op_addi, 4'd3, 4'd0, 4'd0, 16'hfffb);
	add_instr(cpu_pkg::op_or, 4'd4, 4'd0, 4'd0, 16'h0);
	release_reset();
	end_test();
endtask

task automatic random_program_test();
	logic [31:0] r;
	logic [31:0] s;
	start_test("random_program");
	rand_delay = 1'b1;
	for (int i = 0; i < 40; i++) begin
		r = $random(seed);
		s = $random(seed);
		add_instr(cpu_pkg::opcode_t'(4'(r % 6)), s[3:0], s[7:4], s[11:8], s[27:12]);
	end
	release_reset();
	end_test();
endtask

initial begin
	rst_n = 1'b0;
	reset_fetch_test();
	independent_ops_test();
	dependency_chain_test();
	zero_register_test();
	random_program_test();
	$display("tests run %0d, tests with errors %0d, check errors %0d",
		tests_run, tests_failed, errors);
	if (errors == 0)
		$display("Verification passed");
	else
		$display("Verification failed");
	$finish;
end

endmodule
